//--- emu_ram_model.f
+incdir+src
src/emu_ram_pkg.sv
src/burst_if.sv
src/ram_timing_fixed.sv
src/burst_addr_gen.sv
src/ram_backing_store.sv
src/emu_ram_model.sv
verif/emu_ram_checker.sv
verif/tb_emu_ram_model.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_emu_ram_model \
    -f emu_ram_model.f \
    -Mdir obj_dir

out=$(./obj_dir/Vtb_emu_ram_model)
echo "$out"
echo "$out" | grep -q "^TB PASSED$"

//--- src/burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen import emu_ram_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    burst_if.gen    bus
);

    size_t  size_q;
    len_t   len_q;
    burst_t burst_q;
    addr_t  incr;
    addr_t  wrap_mask;
    addr_t  next_addr;

    assign incr = addr_t'(1) << size_q;   // bytes per beat

    // window of (len+1) beats, a power of two for every legal WRAP length
    assign wrap_mask = ((addr_t'(len_q) + addr_t'(1)) << size_q) - addr_t'(1);

    always_comb begin
        case (burst_q)
            BURST_FIXED: next_addr = bus.beat_addr;
            BURST_WRAP: begin
                // keep the window base and wrap the offset inside it
                next_addr = (bus.beat_addr & ~wrap_mask)
                          | ((bus.beat_addr + incr) & wrap_mask);
            end
            default: next_addr = bus.beat_addr + incr;  // reserved type steps like INCR
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            burst_q <= BURST_INCR;
        end else if (bus.start) begin
            burst_q <= bus.burst;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            size_q <= bus.size;
            len_q  <= bus.len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.beat_addr <= '0;
        end else if (bus.start) begin
            bus.beat_addr <= bus.addr;
        end else if (bus.step) begin
            bus.beat_addr <= next_addr;
        end
    end

    a_wrap_len: assert property (@(posedge clk) disable iff (rst)
        bus.start && bus.burst == BURST_WRAP |-> bus.len inside {8'd1, 8'd3, 8'd7, 8'd15});

endmodule

//--- src/burst_if.sv
`timescale 1ns/1ps

interface burst_if import emu_ram_pkg::*; ();

    logic   start;      // address handshake of this direction
    logic   step;       // data beat handshake
    addr_t  addr;       // request fields, valid while start is high
    len_t   len;
    size_t  size;
    burst_t burst;
    addr_t  beat_addr;  // address of the beat currently on the data channel

    // the timing model drives the strobes and request fields
    modport tm (
        output start,
        output step,
        output addr,
        output len,
        output size,
        output burst
    );

    // the address generator follows them and returns the beat address
    modport gen (
        input  start,
        input  step,
        input  addr,
        input  len,
        input  size,
        input  burst,
        output beat_addr
    );

endinterface

//--- src/emu_ram_defines.svh
`ifndef EMU_RAM_DEFINES_SVH
`define EMU_RAM_DEFINES_SVH

// AXI bus widths
`define EMU_ADDR_WIDTH      32
`define EMU_ID_WIDTH        4
`define EMU_DATA_WIDTH      32

// fixed response latencies in clock cycles
`define EMU_R_DELAY         25   // AR handshake to first rvalid
`define EMU_W_DELAY         3    // last W handshake to bvalid

// backing store holds 2**EMU_MEM_WORDS_LOG2 data words
`define EMU_MEM_WORDS_LOG2  10

// delay counters must be wide enough for the larger delay
`define EMU_CNT_WIDTH       16

`endif

//--- src/emu_ram_model.sv
`timescale 1ns/1ps
`include "emu_ram_defines.svh"

module emu_ram_model import emu_ram_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    arvalid,
    output logic    arready,
    input  id_t     arid,
    input  addr_t   araddr,
    input  len_t    arlen,
    input  size_t   arsize,
    input  burst_t  arburst,

    input  logic    awvalid,
    output logic    awready,
    input  id_t     awid,
    input  addr_t   awaddr,
    input  len_t    awlen,
    input  size_t   awsize,
    input  burst_t  awburst,

    input  logic    wvalid,
    output logic    wready,
    input  data_t   wdata,
    input  strb_t   wstrb,
    input  logic    wlast,

    output logic    bvalid,
    input  logic    bready,
    output id_t     bid,

    output logic    rvalid,
    input  logic    rready,
    output id_t     rid,
    output data_t   rdata,
    output logic    rlast
);

    // byte offset bits dropped to form the word index
    localparam int unsigned WORD_LSB = $clog2(`EMU_DATA_WIDTH / 8);

    burst_if rd_burst ();
    burst_if wr_burst ();

    ram_timing_fixed u_timing (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .arlen   (arlen),
        .araddr  (araddr),
        .arsize  (arsize),
        .arburst (arburst),
        .awvalid (awvalid),
        .awready (awready),
        .awid    (awid),
        .awlen   (awlen),
        .awaddr  (awaddr),
        .awsize  (awsize),
        .awburst (awburst),
        .wvalid  (wvalid),
        .wready  (wready),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bid     (bid),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rlast   (rlast),
        .rd      (rd_burst.tm),
        .wr      (wr_burst.tm)
    );

    burst_addr_gen u_rd_gen (
        .clk (clk),
        .rst (rst),
        .bus (rd_burst.gen)
    );

    burst_addr_gen u_wr_gen (
        .clk (clk),
        .rst (rst),
        .bus (wr_burst.gen)
    );

    // the write step strobe is the W handshake, so it doubles as write enable
    ram_backing_store u_store (
        .clk   (clk),
        .we    (wr_burst.step),
        .waddr (wr_burst.beat_addr[WORD_LSB +: `EMU_MEM_WORDS_LOG2]),
        .wdata (wdata),
        .wstrb (wstrb),
        .raddr (rd_burst.beat_addr[WORD_LSB +: `EMU_MEM_WORDS_LOG2]),
        .rdata (rdata)
    );

endmodule

//--- src/emu_ram_pkg.sv
`include "emu_ram_defines.svh"

package emu_ram_pkg;

    typedef logic [`EMU_ADDR_WIDTH-1:0]     addr_t;       // byte address
    typedef logic [`EMU_ID_WIDTH-1:0]       id_t;
    typedef logic [`EMU_DATA_WIDTH-1:0]     data_t;
    typedef logic [`EMU_DATA_WIDTH/8-1:0]   strb_t;       // one bit per data byte
    typedef logic [7:0]                     len_t;        // beats minus one
    typedef logic [2:0]                     size_t;       // log2 of bytes per beat
    typedef logic [1:0]                     burst_t;
    typedef logic [`EMU_MEM_WORDS_LOG2-1:0] word_addr_t;  // index into the store

    // AXI burst type encodings
    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;
    localparam burst_t BURST_WRAP  = 2'd2;

endpackage

//--- src/ram_backing_store.sv
`timescale 1ns/1ps
`include "emu_ram_defines.svh"

module ram_backing_store import emu_ram_pkg::*; (
    input  logic        clk,
    input  logic        we,
    input  word_addr_t  waddr,
    input  data_t       wdata,
    input  strb_t       wstrb,
    input  word_addr_t  raddr,
    output data_t       rdata
);

    localparam int unsigned DEPTH = 1 << `EMU_MEM_WORDS_LOG2;
    localparam int unsigned NBYTES = `EMU_DATA_WIDTH / 8;

    data_t mem [DEPTH];

    // only the strobed byte lanes change
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (wstrb[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = mem[raddr];  // asynchronous read like distributed RAM

endmodule

//--- src/ram_timing_fixed.sv
`timescale 1ns/1ps
`include "emu_ram_defines.svh"

module ram_timing_fixed import emu_ram_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    arvalid,
    output logic    arready,
    input  id_t     arid,
    input  len_t    arlen,
    input  addr_t   araddr,
    input  size_t   arsize,
    input  burst_t  arburst,

    input  logic    awvalid,
    output logic    awready,
    input  id_t     awid,
    input  len_t    awlen,
    input  addr_t   awaddr,
    input  size_t   awsize,
    input  burst_t  awburst,

    input  logic    wvalid,
    output logic    wready,
    input  logic    wlast,

    output logic    bvalid,
    input  logic    bready,
    output id_t     bid,

    output logic    rvalid,
    input  logic    rready,
    output id_t     rid,
    output logic    rlast,

    burst_if.tm     rd,
    burst_if.tm     wr
);

    localparam logic [`EMU_CNT_WIDTH-1:0] R_DELAY = `EMU_CNT_WIDTH'(`EMU_R_DELAY);
    localparam logic [`EMU_CNT_WIDTH-1:0] W_DELAY = `EMU_CNT_WIDTH'(`EMU_W_DELAY);

    logic                       rd_open;    // read accepted, beats outstanding
    logic                       aw_open;    // write address accepted, B not yet taken
    logic                       w_done;     // last W beat seen
    logic [`EMU_CNT_WIDTH-1:0]  rcnt;
    logic [`EMU_CNT_WIDTH-1:0]  wcnt;
    len_t                       rlen;       // read beats left after the current one
    len_t                       wlen;       // write beats left after the current one
    id_t                        rid_q;
    id_t                        bid_q;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign r_hs  = rvalid && rready;
    assign b_hs  = bvalid && bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_open <= 1'b0;
        end else if (ar_hs) begin
            rd_open <= 1'b1;
        end else if (r_hs && rlast) begin
            rd_open <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_open <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_open <= 1'b1;
            end else if (b_hs) begin
                aw_open <= 1'b0;
            end
            if (w_hs && wlast) begin
                w_done <= 1'b1;
            end else if (b_hs) begin
                w_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rcnt <= '0;
            wcnt <= '0;
        end else begin
            if (ar_hs) begin
                rcnt <= R_DELAY;
            end else if (rcnt != '0) begin
                rcnt <= rcnt - 1'b1;
            end
            if (w_hs && wlast) begin
                wcnt <= W_DELAY;
            end else if (wcnt != '0) begin
                wcnt <= wcnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rlen <= '0;
            wlen <= '0;
        end else begin
            if (ar_hs) begin
                rlen <= arlen;
            end else if (r_hs) begin
                rlen <= rlen - 1'b1;
            end
            if (aw_hs) begin
                wlen <= awlen;
            end else if (w_hs) begin
                wlen <= wlen - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rid_q <= arid;
        end
        if (aw_hs) begin
            bid_q <= awid;
        end
    end

    assign arready = !rd_open;
    assign awready = !aw_open;
    assign wready  = aw_open && !w_done;   // closes after wlast until the B handshake

    assign rvalid  = rd_open && rcnt == '0;
    assign rlast   = rlen == '0;
    assign rid     = rid_q;

    assign bvalid  = w_done && wcnt == '0;
    assign bid     = bid_q;

    assign rd.start = ar_hs;
    assign rd.step  = r_hs;
    assign rd.addr  = araddr;
    assign rd.len   = arlen;
    assign rd.size  = arsize;
    assign rd.burst = arburst;

    assign wr.start = aw_hs;
    assign wr.step  = w_hs;
    assign wr.addr  = awaddr;
    assign wr.len   = awlen;
    assign wr.size  = awsize;
    assign wr.burst = awburst;

    // a stalled read beat must stay on the bus unchanged
    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rid) && $stable(rlast));

    // the master must mark exactly beat awlen as the last one
    a_wlast_beat: assert property (@(posedge clk) disable iff (rst)
        w_hs |-> wlast == (wlen == '0));

endmodule

//--- verif/emu_ram_checker.sv
`timescale 1ns/1ps
`include "emu_ram_defines.svh"

module emu_ram_checker import emu_ram_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    arvalid,
    input  logic    arready,
    input  id_t     arid,
    input  addr_t   araddr,
    input  len_t    arlen,
    input  size_t   arsize,
    input  burst_t  arburst,
    input  logic    awvalid,
    input  logic    awready,
    input  id_t     awid,
    input  addr_t   awaddr,
    input  len_t    awlen,
    input  size_t   awsize,
    input  burst_t  awburst,
    input  logic    wvalid,
    input  logic    wready,
    input  data_t   wdata,
    input  strb_t   wstrb,
    input  logic    wlast,
    input  logic    bvalid,
    input  logic    bready,
    input  id_t     bid,
    input  logic    rvalid,
    input  logic    rready,
    input  id_t     rid,
    input  data_t   rdata,
    input  logic    rlast,
    input  addr_t   exp_last,
    output int      data_errs,
    output int      proto_errs,
    output int      time_errs
);

    localparam int NBYTES = `EMU_DATA_WIDTH / 8;
    localparam int MEM_BYTES = NBYTES << `EMU_MEM_WORDS_LOG2;
    localparam int KIND_DATA = 0;
    localparam int KIND_PROTO = 1;
    localparam int KIND_TIME = 2;

    logic [7:0] ref_mem [MEM_BYTES];
    logic       known [MEM_BYTES];  // byte has been written since reset

    int     cyc;
    logic   idle_seen;
    logic   rd_open;
    addr_t  rd_addr;
    len_t   rd_len;
    size_t  rd_size;
    burst_t rd_burst;
    id_t    rd_id;
    int     rd_beat;
    int     ar_cyc;
    logic   r_wait;
    logic   aw_open;
    logic   w_phase;
    addr_t  wr_addr;
    len_t   wr_len;
    size_t  wr_size;
    burst_t wr_burst;
    id_t    wr_id;
    int     w_cyc;
    logic   b_wait;
    logic   b_pend;
    logic   r_stalled;
    data_t  r_data_q;
    id_t    r_id_q;
    logic   r_last_q;
    logic   b_stalled;
    id_t    b_id_q;

    task automatic mismatch(input int kind, input string name, input logic [31:0] exp,
                            input logic [31:0] act);
        $display("FAILED %0t %s expected %0h got %0h", $time, name, exp, act);
        if (kind == KIND_DATA) begin
            data_errs++;
        end else if (kind == KIND_PROTO) begin
            proto_errs++;
        end else begin
            time_errs++;
        end
    endtask

    // WRAP stays inside an aligned window of (len+1) beats
    function automatic addr_t step_addr(addr_t a, len_t len, size_t size, burst_t burst);
        addr_t bytes;
        addr_t window;
        addr_t base;
        bytes = addr_t'(1) << size;
        window = (addr_t'(len) + addr_t'(1)) * bytes;
        base = a - (a % window);
        case (burst)
            BURST_FIXED: return a;
            BURST_WRAP:  return base + ((a - base + bytes) % window);
            default:     return a + bytes;
        endcase
    endfunction

    function automatic int byte_index(addr_t a, int lane);
        return int'(a % addr_t'(MEM_BYTES)) / NBYTES * NBYTES + lane;
    endfunction

    task automatic check_read_beat();
        data_t exp_word;
        data_t mask;
        int    idx;
        logic  is_last;
        exp_word = '0;
        mask = '0;
        for (int b = 0; b < NBYTES; b++) begin
            idx = byte_index(rd_addr, b);
            if (known[idx]) begin
                exp_word[8*b +: 8] = ref_mem[idx];
                mask[8*b +: 8] = 8'hff;
            end
        end
        is_last = rd_beat == int'(rd_len);
        if ((rdata & mask) !== exp_word) mismatch(KIND_DATA, "rdata", exp_word, rdata);
        if (rid !== rd_id) mismatch(KIND_DATA, "rid", 32'(rd_id), 32'(rid));
        if (rlast !== is_last) mismatch(KIND_PROTO, "rlast", 32'(is_last), 32'(rlast));
        if (is_last) begin
            if (rd_addr !== exp_last) mismatch(KIND_DATA, "read end address", exp_last, rd_addr);
            rd_open = 1'b0;
        end else begin
            rd_addr = step_addr(rd_addr, rd_len, rd_size, rd_burst);
            rd_beat++;
        end
    endtask

    task automatic record_write_beat();
        int idx;
        for (int b = 0; b < NBYTES; b++) begin
            if (wstrb[b]) begin
                idx = byte_index(wr_addr, b);
                ref_mem[idx] = wdata[8*b +: 8];
                known[idx] = 1'b1;
            end
        end
        if (wlast) begin
            if (wr_addr !== exp_last) mismatch(KIND_DATA, "write end address", exp_last, wr_addr);
            w_phase = 1'b0;
            b_pend = 1'b1;
            b_wait = 1'b1;
            w_cyc = cyc;
        end else begin
            wr_addr = step_addr(wr_addr, wr_len, wr_size, wr_burst);
        end
    endtask

    // sampled at the falling edge, so every value is what the next rising edge sees
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                known[i] = 1'b0;
            end
            data_errs = 0;
            proto_errs = 0;
            time_errs = 0;
            cyc = 0;
            idle_seen = 1'b0;
            rd_open = 1'b0;
            r_wait = 1'b0;
            aw_open = 1'b0;
            w_phase = 1'b0;
            b_wait = 1'b0;
            b_pend = 1'b0;
            r_stalled = 1'b0;
            b_stalled = 1'b0;
        end else begin
            cyc++;
            if (!idle_seen) begin
                idle_seen = 1'b1;
                if (arready !== 1'b1) mismatch(KIND_PROTO, "arready", 1, 32'(arready));
                if (awready !== 1'b1) mismatch(KIND_PROTO, "awready", 1, 32'(awready));
                if (wready !== 1'b0) mismatch(KIND_PROTO, "wready", 0, 32'(wready));
                if (rvalid !== 1'b0) mismatch(KIND_PROTO, "rvalid", 0, 32'(rvalid));
                if (bvalid !== 1'b0) mismatch(KIND_PROTO, "bvalid", 0, 32'(bvalid));
            end
            if (r_stalled) begin
                if (rvalid !== 1'b1) mismatch(KIND_PROTO, "rvalid", 1, 32'(rvalid));
                if (rdata !== r_data_q) mismatch(KIND_DATA, "rdata", r_data_q, rdata);
                if (rid !== r_id_q) mismatch(KIND_DATA, "rid", 32'(r_id_q), 32'(rid));
                if (rlast !== r_last_q) mismatch(KIND_PROTO, "rlast", 32'(r_last_q), 32'(rlast));
            end
            r_stalled = rvalid && !rready;
            r_data_q = rdata;
            r_id_q = rid;
            r_last_q = rlast;
            if (b_stalled) begin
                if (bvalid !== 1'b1) mismatch(KIND_PROTO, "bvalid", 1, 32'(bvalid));
                if (bid !== b_id_q) mismatch(KIND_DATA, "bid", 32'(b_id_q), 32'(bid));
            end
            b_stalled = bvalid && !bready;
            b_id_q = bid;
            if (rd_open && arready !== 1'b0) mismatch(KIND_PROTO, "arready", 0, 32'(arready));
            if (aw_open && awready !== 1'b0) mismatch(KIND_PROTO, "awready", 0, 32'(awready));
            if (!w_phase && wready !== 1'b0) mismatch(KIND_PROTO, "wready", 0, 32'(wready));
            if (!rd_open && rvalid !== 1'b0) mismatch(KIND_PROTO, "rvalid", 0, 32'(rvalid));
            if (!b_pend && bvalid !== 1'b0) mismatch(KIND_PROTO, "bvalid", 0, 32'(bvalid));
            if (r_wait && rvalid) begin   // counted in rising edges since the handshake edge
                if (cyc - ar_cyc - 1 != `EMU_R_DELAY) begin
                    mismatch(KIND_TIME, "rvalid latency", `EMU_R_DELAY, 32'(cyc - ar_cyc - 1));
                end
                r_wait = 1'b0;
            end
            if (b_wait && bvalid) begin
                if (cyc - w_cyc - 1 != `EMU_W_DELAY) begin
                    mismatch(KIND_TIME, "bvalid latency", `EMU_W_DELAY, 32'(cyc - w_cyc - 1));
                end
                b_wait = 1'b0;
            end
            if (arvalid && arready) begin
                rd_open = 1'b1;
                rd_addr = araddr;
                rd_len = arlen;
                rd_size = arsize;
                rd_burst = arburst;
                rd_id = arid;
                rd_beat = 0;
                ar_cyc = cyc;
                r_wait = 1'b1;
            end
            if (rvalid && rready) begin
                check_read_beat();
            end
            if (awvalid && awready) begin
                aw_open = 1'b1;
                w_phase = 1'b1;
                wr_addr = awaddr;
                wr_len = awlen;
                wr_size = awsize;
                wr_burst = awburst;
                wr_id = awid;
            end
            if (wvalid && wready) begin
                record_write_beat();
            end
            if (bvalid && bready) begin
                if (bid !== wr_id) mismatch(KIND_DATA, "bid", 32'(wr_id), 32'(bid));
                aw_open = 1'b0;
                b_pend = 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_emu_ram_model.sv
`timescale 1ns/1ps
`include "emu_ram_defines.svh"

module tb_emu_ram_model import emu_ram_pkg::*; ();

    localparam logic WR = 1'b1;
    localparam logic RD = 1'b0;
    localparam int NROWS = 18;
    localparam int LIMIT_CYCLES = NROWS * (`EMU_R_DELAY + 4 * 256 + 20);

    typedef struct packed {
        logic   dir;
        id_t    id;
        addr_t  addr;
        len_t   len;
        size_t  size;
        burst_t burst;
        strb_t  strb;
        addr_t  last;   // address of the final beat, worked out by hand
    } row_t;

    localparam row_t ROWS [NROWS] = '{
        '{WR, 4'h1, 32'h100, 8'd3,  3'd2, BURST_INCR,  4'hf, 32'h10c},
        '{WR, 4'h2, 32'h200, 8'd7,  3'd2, BURST_INCR,  4'hf, 32'h21c},
        '{WR, 4'h3, 32'h300, 8'd0,  3'd2, BURST_INCR,  4'hf, 32'h300},
        '{WR, 4'h4, 32'h600, 8'd15, 3'd2, BURST_INCR,  4'hf, 32'h63c},
        '{RD, 4'h5, 32'h100, 8'd3,  3'd2, BURST_INCR,  4'h0, 32'h10c},
        '{RD, 4'h6, 32'h200, 8'd7,  3'd2, BURST_INCR,  4'h0, 32'h21c},
        '{RD, 4'h7, 32'h300, 8'd0,  3'd2, BURST_INCR,  4'h0, 32'h300},
        '{RD, 4'h8, 32'h600, 8'd15, 3'd2, BURST_INCR,  4'h0, 32'h63c},
        '{WR, 4'h9, 32'h108, 8'd3,  3'd2, BURST_WRAP,  4'hf, 32'h104},  // starts mid-window
        '{RD, 4'ha, 32'h10c, 8'd3,  3'd2, BURST_WRAP,  4'h0, 32'h108},
        '{WR, 4'hb, 32'h518, 8'd7,  3'd2, BURST_WRAP,  4'hf, 32'h514},
        '{RD, 4'hc, 32'h510, 8'd7,  3'd2, BURST_WRAP,  4'h0, 32'h50c},
        '{WR, 4'hd, 32'h400, 8'd3,  3'd2, BURST_FIXED, 4'hf, 32'h400},
        '{RD, 4'he, 32'h400, 8'd1,  3'd2, BURST_FIXED, 4'h0, 32'h400},
        '{WR, 4'hf, 32'h202, 8'd0,  3'd1, BURST_INCR,  4'hc, 32'h202},  // narrow halfword
        '{WR, 4'h0, 32'h211, 8'd0,  3'd0, BURST_INCR,  4'h2, 32'h211},  // narrow byte
        '{WR, 4'h1, 32'h204, 8'd1,  3'd2, BURST_INCR,  4'h5, 32'h208},
        '{RD, 4'h2, 32'h200, 8'd7,  3'd2, BURST_INCR,  4'h0, 32'h21c}
    };

    logic   clk;
    logic   rst;
    logic   arvalid;
    logic   arready;
    id_t    arid;
    addr_t  araddr;
    len_t   arlen;
    size_t  arsize;
    burst_t arburst;
    logic   awvalid;
    logic   awready;
    id_t    awid;
    addr_t  awaddr;
    len_t   awlen;
    size_t  awsize;
    burst_t awburst;
    logic   wvalid;
    logic   wready;
    data_t  wdata;
    strb_t  wstrb;
    logic   wlast;
    logic   bvalid;
    logic   bready;
    id_t    bid;
    logic   rvalid;
    logic   rready;
    id_t    rid;
    data_t  rdata;
    logic   rlast;
    addr_t  exp_last;
    int     data_errs;
    int     proto_errs;
    int     time_errs;

    logic [31:0] rng_state = 32'd75733;

    emu_ram_model i_emu_ram_model (.*);

    emu_ram_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ready is high on about three cycles out of four
    function automatic logic ready_bit();
        return (next_rand() & 32'h3) != 32'h0;
    endfunction

    task automatic run_write(input row_t r);
        int   beat;
        logic done;
        awvalid <= 1'b1;
        awid <= r.id;
        awaddr <= r.addr;
        awlen <= r.len;
        awsize <= r.size;
        awburst <= r.burst;
        exp_last <= r.last;
        do @(negedge clk); while (!awready);
        @(posedge clk);
        awvalid <= 1'b0;
        for (beat = 0; beat <= int'(r.len); beat++) begin
            wvalid <= 1'b1;
            wdata <= next_rand();
            wstrb <= r.strb;
            wlast <= (beat == int'(r.len));
            do @(negedge clk); while (!wready);
            @(posedge clk);
        end
        wvalid <= 1'b0;
        wlast <= 1'b0;
        done = 1'b0;
        bready <= ready_bit();
        while (!done) begin
            @(negedge clk);
            done = bvalid && bready;
            @(posedge clk);
            bready <= done ? 1'b0 : ready_bit();
        end
    endtask

    task automatic run_read(input row_t r);
        int beat;
        arvalid <= 1'b1;
        arid <= r.id;
        araddr <= r.addr;
        arlen <= r.len;
        arsize <= r.size;
        arburst <= r.burst;
        exp_last <= r.last;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        beat = 0;
        rready <= ready_bit();
        while (beat <= int'(r.len)) begin
            @(negedge clk);
            if (rvalid && rready) begin
                beat++;
            end
            @(posedge clk);
            rready <= (beat <= int'(r.len)) ? ready_bit() : 1'b0;
        end
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the transaction table did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = '0;
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        exp_last = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);  // the checker looks at the idle outputs here
        for (int i = 0; i < NROWS; i++) begin
            if (ROWS[i].dir == WR) begin
                run_write(ROWS[i]);
            end else begin
                run_read(ROWS[i]);
            end
        end
        repeat (4) @(posedge clk);
        $display("errors: data %0d, protocol %0d, timing %0d", data_errs, proto_errs, time_errs);
        if (data_errs + proto_errs + time_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
